//--- board_periph_macros.svh
// Board peripheral constants and register map; include where sizes or offsets are needed
`ifndef BOARD_PERIPH_MACROS_SVH
`define BOARD_PERIPH_MACROS_SVH

// Console transmit FIFO entries
`define BOARD_TX_FIFO_DEPTH 8

// soc_clk cycles per UART bit
`define BOARD_UART_CLKS_PER_BIT 16

// Terminal count of the RTC counter, tick toggles every count+1 cycles
`define BOARD_RTC_HALF_PERIOD 24

// Register offsets on the APB slave
// TXDATA is write only
`define BOARD_REG_TXDATA 12'h000
// STATUS is read only, bit 0 full, bit 1 empty, bit 2 busy, bits 7:4 level
`define BOARD_REG_STATUS 12'h004
// SCRATCH is a plain 32-bit read/write register
`define BOARD_REG_SCRATCH 12'h008

`endif

//--- board_periph_pkg.sv
// Shared console and board types; imported by the board peripheral RTL and testbench
package board_periph_pkg;

  ////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////

  // One console character
  typedef logic [7:0]  byte_t;

  // APB byte address and data word
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // FIFO occupancy, 0 up to and including the depth
  typedef logic [3:0]  fifo_level_t;

  // Fan duty in high cycles per 16-cycle frame
  typedef logic [3:0]  fan_duty_t;

  ////////////////////////////////////////
  // UART transmitter FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

//--- board_reset_sync.sv
// Board reset synchronizer; instantiated at the top to derive the SoC reset from rst_n
module board_reset_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic soc_rst_n_o
);

  logic [1:0] sync_q;

  // Assertion is asynchronous, release walks through two flops
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Test mode hands the raw board reset straight through
  assign soc_rst_n_o = test_mode_i ? rst_n : sync_q[1];

endmodule

//--- board_rtc_div.sv
// Real-time-clock tick divider; turns soc_clk into a slow square wave for the RTC input
`include "board_periph_macros.svh"

module board_rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned CntW = $clog2(`BOARD_RTC_HALF_PERIOD + 1);

  logic [CntW-1:0] cnt_q;
  logic            tick_q;
  logic            wrap;

  assign wrap = (cnt_q == CntW'(`BOARD_RTC_HALF_PERIOD));

  // Wrap and toggle once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else if (wrap) begin
      cnt_q  <= '0;
      tick_q <= ~tick_q;
    end else begin
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = tick_q;

endmodule

//--- board_fan_pwm.sv
// Fan PWM generator; drives the cooling fan from the 4-bit switch duty setting
module board_fan_pwm (
  input  logic                       soc_clk,
  input  logic                       rst_n,
  input  board_periph_pkg::fan_duty_t duty_i,
  output logic                       fan_pwm_o
);

  import board_periph_pkg::*;

  fan_duty_t frame_q;
  fan_duty_t duty_q;
  logic      pwm_q;

  // Free-running 16-cycle frame
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q <= '0;
    end else begin
      frame_q <= frame_q + 1'b1;
    end
  end

  // Switches are sampled once, output registered for a clean fan driver
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      duty_q <= duty_i;
      pwm_q  <= (frame_q < duty_q);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- board_apb_regs.sv
// APB console register slave; pushes TXDATA bytes into the transmit FIFO and reports status
`include "board_periph_macros.svh"

module board_apb_regs (
  input  logic                         soc_clk,
  input  logic                         rst_n,

  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  board_periph_pkg::apb_addr_t  paddr_i,
  input  board_periph_pkg::apb_data_t  pwdata_i,
  output board_periph_pkg::apb_data_t  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,

  // FIFO push side
  output logic                         push_o,
  output board_periph_pkg::byte_t      push_data_o,

  // Status inputs
  input  logic                         full_i,
  input  logic                         empty_i,
  input  logic                         busy_i,
  input  board_periph_pkg::fifo_level_t level_i
);

  import board_periph_pkg::*;

  ////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////

  logic      access;
  logic      hit_txdata;
  logic      hit_status;
  logic      hit_scratch;
  logic      unmapped;
  apb_data_t scratch_q;
  apb_data_t status_word;

  // Only the access phase does anything
  assign access = psel_i & penable_i;

  assign hit_txdata  = (paddr_i == `BOARD_REG_TXDATA);
  assign hit_status  = (paddr_i == `BOARD_REG_STATUS);
  assign hit_scratch = (paddr_i == `BOARD_REG_SCRATCH);
  assign unmapped    = ~(hit_txdata | hit_status | hit_scratch);

  // No wait states
  assign pready_o = 1'b1;

  // Refused TXDATA writes, STATUS writes and holes in the map
  assign pslverr_o = access & ((pwrite_i & hit_txdata & full_i) |
                               (pwrite_i & hit_status) |
                               unmapped);

  ////////////////////////////////////////
  // Push and SCRATCH
  ////////////////////////////////////////

  assign push_o      = access & pwrite_i & hit_txdata & ~full_i;
  assign push_data_o = pwdata_i[7:0];

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q <= '0;
    end else if (access && pwrite_i && hit_scratch) begin
      scratch_q <= pwdata_i;
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  assign status_word = {24'h0, level_i, 1'b0, busy_i, empty_i, full_i};

  // TXDATA reads back as zero
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      if (hit_status) begin
        prdata_o = status_word;
      end else if (hit_scratch) begin
        prdata_o = scratch_q;
      end
    end
  end

endmodule

//--- board_tx_fifo.sv
// Console transmit FIFO; buffers bytes between the APB register block and the UART
`include "board_periph_macros.svh"

module board_tx_fifo (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  logic                          push_i,
  input  board_periph_pkg::byte_t       data_i,
  input  logic                          pop_i,
  output board_periph_pkg::byte_t       data_o,
  output logic                          full_o,
  output logic                          empty_o,
  output board_periph_pkg::fifo_level_t level_o
);

  import board_periph_pkg::*;

  localparam int unsigned Depth = `BOARD_TX_FIFO_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  byte_t       mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  fifo_level_t level_q;

  // Storage, written only on a push
  always_ff @(posedge soc_clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the last entry; level tracks push minus pop
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        level_q <= level_q + 1'b1;
      end else if (pop_i && !push_i) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // Head entry is always visible
  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (level_q == fifo_level_t'(Depth));
  assign empty_o = (level_q == '0);
  assign level_o = level_q;

endmodule

//--- board_uart_tx.sv
// 8N1 UART transmitter; drains the console FIFO onto the board's serial line
`include "board_periph_macros.svh"

module board_uart_tx (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic                    empty_i,
  input  board_periph_pkg::byte_t data_i,
  output logic                    pop_o,
  output logic                    busy_o,
  output logic                    uart_tx_o
);

  import board_periph_pkg::*;

  localparam int unsigned ClksPerBit = `BOARD_UART_CLKS_PER_BIT;
  localparam int unsigned CntW       = $clog2(ClksPerBit);

  uart_state_e     state_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [2:0]      bit_idx_q;
  byte_t           shift_q;
  logic            tx_q;
  logic            bit_end;

  assign bit_end = (clk_cnt_q == CntW'(ClksPerBit - 1));

  // Take the head byte as soon as the line is idle
  assign pop_o  = (state_q == UART_IDLE) & ~empty_i;
  assign busy_o = (state_q != UART_IDLE);

  ////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
      unique case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          if (pop_o) begin
            state_q <= UART_START;
            tx_q    <= 1'b0;
          end
        end
        UART_START: begin
          if (bit_end) begin
            state_q   <= UART_DATA;
            bit_idx_q <= '0;
            tx_q      <= shift_q[0];
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            if (bit_idx_q == 3'd7) begin
              state_q <= UART_STOP;
              tx_q    <= 1'b1;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              tx_q      <= shift_q[0];
            end
          end
        end
        UART_STOP: begin
          if (bit_end) begin
            state_q <= UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // Data shifter, LSB leaves first
  always_ff @(posedge soc_clk) begin
    if (pop_o) begin
      shift_q <= data_i;
    end else if (bit_end && (state_q == UART_START || state_q == UART_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign uart_tx_o = tx_q;

endmodule

//--- board_periph_top.sv
// Board peripheral top level; wires reset sync, RTC tick, fan PWM and the console TX path
module board_periph_top (
  input  logic                         soc_clk,
  input  logic                         rst_n,
  input  logic                         test_mode_i,

  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  board_periph_pkg::apb_addr_t  paddr_i,
  input  board_periph_pkg::apb_data_t  pwdata_i,
  output board_periph_pkg::apb_data_t  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,

  // Board IO
  input  board_periph_pkg::fan_duty_t  fan_sw_i,
  output logic                         uart_tx_o,
  output logic                         rtc_o,
  output logic                         fan_pwm_o
);

  import board_periph_pkg::*;

  logic        soc_rst_n;
  logic        push;
  byte_t       push_data;
  logic        pop;
  byte_t       fifo_data;
  logic        fifo_full;
  logic        fifo_empty;
  fifo_level_t fifo_level;
  logic        uart_busy;

  ////////////////////////////////////////
  // Reset, RTC and fan
  ////////////////////////////////////////

  board_reset_sync i_reset_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_n_o ( soc_rst_n   )
  );

  board_rtc_div i_rtc_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  board_fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .duty_i    ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////////////////////////
  // Console transmit path
  ////////////////////////////////////////

  board_apb_regs i_apb_regs (
    .soc_clk     ( soc_clk    ),
    .rst_n       ( soc_rst_n  ),
    .psel_i      ( psel_i     ),
    .penable_i   ( penable_i  ),
    .pwrite_i    ( pwrite_i   ),
    .paddr_i     ( paddr_i    ),
    .pwdata_i    ( pwdata_i   ),
    .prdata_o    ( prdata_o   ),
    .pready_o    ( pready_o   ),
    .pslverr_o   ( pslverr_o  ),
    .push_o      ( push       ),
    .push_data_o ( push_data  ),
    .full_i      ( fifo_full  ),
    .empty_i     ( fifo_empty ),
    .busy_i      ( uart_busy  ),
    .level_i     ( fifo_level )
  );

  board_tx_fifo i_tx_fifo (
    .soc_clk ( soc_clk    ),
    .rst_n   ( soc_rst_n  ),
    .push_i  ( push       ),
    .data_i  ( push_data  ),
    .pop_i   ( pop        ),
    .data_o  ( fifo_data  ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty ),
    .level_o ( fifo_level )
  );

  board_uart_tx i_uart_tx (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( soc_rst_n  ),
    .empty_i   ( fifo_empty ),
    .data_i    ( fifo_data  ),
    .pop_o     ( pop        ),
    .busy_o    ( uart_busy  ),
    .uart_tx_o ( uart_tx_o  )
  );

endmodule

//--- board_periph_properties.sv
// Concurrent checks on the APB handshake and UART idle line; bound into board_periph_top
module board_periph_properties (
  input logic soc_clk,
  input logic rst_n,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic fifo_empty_i,
  input logic uart_busy_i,
  input logic uart_tx_i
);

  // Failures so far, summed into the final result
  int unsigned fail_count = 0;

  // No wait states on this slave
  pready_high: assert property (@(posedge soc_clk) disable iff (!rst_n) pready_i)
    else begin
      $error("pready_o dropped low");
      fail_count++;
    end

  // Error response belongs to the access phase only
  pslverr_in_access: assert property (@(posedge soc_clk) disable iff (!rst_n)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      $error("pslverr_o raised outside an APB access cycle");
      fail_count++;
    end

  // Nothing queued and nothing shifting means a marking line
  line_idle_high: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (fifo_empty_i && !uart_busy_i) |-> uart_tx_i)
    else begin
      $error("uart_tx_o low while the FIFO is empty and the UART is idle");
      fail_count++;
    end

endmodule

bind board_periph_top board_periph_properties i_props (
  .soc_clk      ( soc_clk    ),
  .rst_n        ( soc_rst_n  ),
  .psel_i       ( psel_i     ),
  .penable_i    ( penable_i  ),
  .pready_i     ( pready_o   ),
  .pslverr_i    ( pslverr_o  ),
  .fifo_empty_i ( fifo_empty ),
  .uart_busy_i  ( uart_busy  ),
  .uart_tx_i    ( uart_tx_o  )
);

//--- tb_board_periph.sv
// Testbench for the board peripheral top; plays the APB master and watches the UART line
`include "board_periph_macros.svh"

module tb_board_periph;

  import board_periph_pkg::*;

  localparam int ClkPeriod = 100;
  localparam int BitClks   = `BOARD_UART_CLKS_PER_BIT;
  localparam int FrameClks = 10 * BitClks;
  localparam int NumSingle = 4;
  localparam int NumBurst  = 14;
  // Two frame times per byte, plus room for reset, registers, RTC and fan
  localparam int WatchdogCycles = (NumSingle + NumBurst) * FrameClks * 2 + 3000;

  logic        soc_clk;
  logic        rst_n;
  logic        test_mode;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  fan_duty_t   fan_sw;
  logic        uart_tx;
  logic        rtc;
  logic        fan_pwm;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          rx_count = 0;
  logic [9:0]  rx_frame;
  byte_t       exp_q[$];
  event        frame_done;

  board_periph_top uut (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .test_mode_i ( test_mode ),
    .psel_i      ( psel      ),
    .penable_i   ( penable   ),
    .pwrite_i    ( pwrite    ),
    .paddr_i     ( paddr     ),
    .pwdata_i    ( pwdata    ),
    .prdata_o    ( prdata    ),
    .pready_o    ( pready    ),
    .pslverr_o   ( pslverr   ),
    .fan_sw_i    ( fan_sw    ),
    .uart_tx_o   ( uart_tx   ),
    .rtc_o       ( rtc       ),
    .fan_pwm_o   ( fan_pwm   )
  );

  initial soc_clk = 1'b0;
  always #(ClkPeriod / 2) soc_clk = ~soc_clk;

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // Line frame of one byte, start bit in bit 0, data LSB first, stop bit in bit 9
  function automatic logic [9:0] expected_frame(input byte_t data);
    expected_frame = {1'b1, data, 1'b0};
  endfunction

  // STATUS layout from the register map
  function automatic apb_data_t expected_status(input logic full, input logic empty,
                                                input logic busy, input fifo_level_t level);
    expected_status      = '0;
    expected_status[0]   = full;
    expected_status[1]   = empty;
    expected_status[2]   = busy;
    expected_status[7:4] = level;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got_val,
                             input logic [31:0] exp_val);
    checks++;
    assert (got_val === exp_val) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
    end
  endtask

  // Starts and ends on a falling edge, bus idle at the end
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge soc_clk);
    penable = 1'b1;
    // Response read mid-way through the access cycle
    #(ClkPeriod / 4);
    check_value("pready_o", 32'(pready), 32'd1);
    rdata = prdata;
    err   = pslverr;
    @(negedge soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_frames(input int count, input int limit);
    int n;
    n = 0;
    while (rx_count < count && n < limit) begin
      @(negedge soc_clk);
      n++;
    end
    checks++;
    assert (rx_count >= count) else begin
      errors++;
      $display("Timed out after %0d cycles waiting for frame %0d on uart_tx_o", n, count);
    end
    // Lets the comparing process consume the last frame
    @(negedge soc_clk);
  endtask

  task automatic check_rtc();
    logic prev;
    int   gap;
    int   edges;
    int   cycles;
    prev   = rtc;
    gap    = 0;
    edges  = 0;
    cycles = 0;
    while (edges < 4 && cycles < 200) begin
      @(negedge soc_clk);
      cycles++;
      gap++;
      if (rtc !== prev) begin
        if (edges > 0) begin
          check_value("rtc_o half period", 32'(gap), 32'(`BOARD_RTC_HALF_PERIOD + 1));
        end
        prev = rtc;
        gap  = 0;
        edges++;
      end
    end
    checks++;
    assert (edges == 4) else begin
      errors++;
      $display("rtc_o stopped toggling, only %0d edges in %0d cycles", edges, cycles);
    end
  endtask

  task automatic check_fan(input fan_duty_t duty);
    int highs;
    fan_sw = duty;
    // Duty and output registers settle well within two frames
    repeat (32) @(negedge soc_clk);
    for (int w = 0; w < 2; w++) begin
      highs = 0;
      repeat (16) begin
        @(negedge soc_clk);
        if (fan_pwm) begin
          highs++;
        end
      end
      check_value("fan_pwm_o high cycles", 32'(highs), 32'(duty));
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("%s finished with %0d errors", name, errors - err_start);
  endtask

  ////////////////////////////////////////
  // UART line monitor and comparison
  ////////////////////////////////////////

  // One sample per falling clock edge, bit value taken mid-bit
  initial begin : line_monitor
    logic [9:0] bits;
    logic       first;
    logic       stable;
    forever begin
      @(negedge uart_tx);
      bits   = '0;
      stable = 1'b1;
      for (int k = 0; k < FrameClks; k++) begin
        @(negedge soc_clk);
        if (k % BitClks == 0) begin
          first = uart_tx;
        end else if (uart_tx !== first) begin
          stable = 1'b0;
        end
        if (k % BitClks == BitClks / 2) begin
          bits = {uart_tx, bits[9:1]};
        end
      end
      checks++;
      assert (stable) else begin
        errors++;
        $display("uart_tx_o changed inside a bit time in frame %0d", rx_count);
      end
      check_value("uart_tx_o start bit", 32'(bits[0]), 32'd0);
      check_value("uart_tx_o stop bit", 32'(bits[9]), 32'd1);
      rx_frame = bits;
      rx_count++;
      -> frame_done;
    end
  end

  initial begin : frame_compare
    byte_t data;
    forever begin
      @(frame_done);
      checks++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Frame seen on uart_tx_o with no accepted byte pending");
      end
      if (exp_q.size() != 0) begin
        data = exp_q.pop_front();
        check_value("uart_tx_o frame", 32'(rx_frame), 32'(expected_frame(data)));
      end
    end
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    apb_data_t rdata;
    logic      err;
    byte_t     data;
    apb_data_t scratch;
    int        err_start;
    int        accepted;
    int        base;
    void'($urandom(32'hc0d34597));
    rst_n     = 1'b0;
    test_mode = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    fan_sw    = '0;
    repeat (2) @(negedge soc_clk);
    rst_n = 1'b1;
    repeat (4) @(negedge soc_clk);

    // Reset state
    err_start = errors;
    check_value("uart_tx_o", 32'(uart_tx), 32'd1);
    check_value("fan_pwm_o", 32'(fan_pwm), 32'd0);
    check_value("rtc_o", 32'(rtc), 32'd0);
    check_value("pslverr_o", 32'(pslverr), 32'd0);
    apb_access(1'b0, `BOARD_REG_STATUS, '0, rdata, err);
    check_value("prdata_o STATUS", rdata, expected_status(1'b0, 1'b1, 1'b0, 4'd0));
    apb_access(1'b0, `BOARD_REG_SCRATCH, '0, rdata, err);
    check_value("prdata_o SCRATCH", rdata, 32'd0);
    report_test("Reset state", err_start);

    // SCRATCH and error responses
    err_start = errors;
    scratch = $urandom;
    apb_access(1'b1, `BOARD_REG_SCRATCH, scratch, rdata, err);
    check_value("pslverr_o", 32'(err), 32'd0);
    apb_access(1'b0, `BOARD_REG_SCRATCH, '0, rdata, err);
    check_value("prdata_o SCRATCH", rdata, scratch);
    apb_access(1'b1, `BOARD_REG_STATUS, 32'h5a, rdata, err);
    check_value("pslverr_o STATUS write", 32'(err), 32'd1);
    apb_access(1'b0, 12'h00c, '0, rdata, err);
    check_value("pslverr_o unmapped", 32'(err), 32'd1);
    report_test("SCRATCH register", err_start);

    // Single bytes with gaps
    err_start = errors;
    for (int i = 0; i < NumSingle; i++) begin
      data = byte_t'($urandom);
      apb_access(1'b1, `BOARD_REG_TXDATA, {24'h0, data}, rdata, err);
      check_value("pslverr_o", 32'(err), 32'd0);
      exp_q.push_back(data);
      // Push on the access edge, pop on the next, start bit right after
      check_value("uart_tx_o before start", 32'(uart_tx), 32'd1);
      @(negedge soc_clk);
      check_value("uart_tx_o start", 32'(uart_tx), 32'd0);
      wait_frames(rx_count + 1, 2 * FrameClks);
      repeat (10 + i * 7) @(negedge soc_clk);
      apb_access(1'b0, `BOARD_REG_STATUS, '0, rdata, err);
      check_value("prdata_o STATUS", rdata, expected_status(1'b0, 1'b1, 1'b0, 4'd0));
    end
    report_test("Single bytes", err_start);

    // Burst against a full FIFO
    err_start = errors;
    accepted  = 0;
    base      = rx_count;
    for (int i = 0; i < NumBurst; i++) begin
      data = byte_t'($urandom);
      apb_access(1'b1, `BOARD_REG_TXDATA, {24'h0, data}, rdata, err);
      // First byte goes straight to the UART, then the FIFO fills up
      check_value("pslverr_o burst write", 32'(err),
                  32'(i > `BOARD_TX_FIFO_DEPTH));
      if (!err) begin
        exp_q.push_back(data);
        accepted++;
      end
    end
    // Still inside the first frame, so the FIFO holds a full load
    apb_access(1'b0, `BOARD_REG_STATUS, '0, rdata, err);
    check_value("prdata_o STATUS", rdata,
                expected_status(1'b1, 1'b0, 1'b1, fifo_level_t'(`BOARD_TX_FIFO_DEPTH)));
    checks++;
    assert (accepted >= `BOARD_TX_FIFO_DEPTH) else begin
      errors++;
      $display("Only %0d of %0d burst writes were accepted", accepted, NumBurst);
    end
    wait_frames(base + accepted, accepted * (FrameClks + 1) + 100);
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d accepted bytes never appeared on uart_tx_o", exp_q.size());
    end
    $display("Burst sent %0d bytes, %0d refused", accepted, NumBurst - accepted);
    report_test("Burst and back-pressure", err_start);

    err_start = errors;
    check_rtc();
    report_test("RTC tick", err_start);

    err_start = errors;
    check_fan(4'd0);
    check_fan(4'd5);
    check_fan(4'd15);
    report_test("Fan PWM", err_start);

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, uut.i_props.fail_count);
    if (errors == 0 && uut.i_props.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
board_periph_pkg.sv
board_reset_sync.sv
board_rtc_div.sv
board_fan_pwm.sv
board_apb_regs.sv
board_tx_fifo.sv
board_uart_tx.sv
board_periph_top.sv
board_periph_properties.sv
tb_board_periph.sv

//--- run_sim.sh
#!/bin/sh
# Builds the board peripheral testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_board_periph \
  -f filelist.f \
  -o sim_tb_board_periph

# Concurrent assertion failures must not stop the run before the summary
./obj_dir/sim_tb_board_periph +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
  echo "Simulation result: PASS"
  exit 0
fi
echo "Simulation result: FAIL, see sim.log"
exit 1
